//--- logic/cpuPkg.sv
/*
 * Shared types for the five-stage core.
 * Word addressed: PC and data addresses step by one per instruction or word.
 * Opcodes outside opcode_e decode as a nop that writes nothing.
 * An all-zero stage register is a bubble.
 */
package cpuPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int immWidth     = 17;
    localparam int targetWidth  = 27;
    localparam int linkReg      = 31;

    typedef logic [dataWidth-1:0]    word_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;

    typedef enum logic [4:0] {
        opRType = 5'd0,
        opJ     = 5'd1,
        opBne   = 5'd2,
        opJal   = 5'd3,
        opAddi  = 5'd5,
        opBlt   = 5'd6,
        opSw    = 5'd7,
        opLw    = 5'd8
    } opcode_e;

    // R-type function field
    typedef enum logic [4:0] {
        aluAdd = 5'd0,
        aluSub = 5'd1,
        aluAnd = 5'd2,
        aluOr  = 5'd3,
        aluSll = 5'd4,
        aluSra = 5'd5
    } aluOp_e;

    // Immediate is bits 16:0 and the jump target bits 26:0
    typedef struct packed {
        opcode_e  opcode;
        regAddr_t rd;
        regAddr_t rs;
        regAddr_t rt;
        logic [4:0] shamt;
        aluOp_e   aluOp;
        logic [1:0] zero;
    } instr_t;

    typedef struct packed {
        word_t  pcPlusOne;
        instr_t instr;
    } fdReg_t;

    typedef struct packed {
        word_t    pcPlusOne;
        instr_t   instr;
        word_t    imm;
        word_t    dataA;
        word_t    dataB;
        regAddr_t srcA;
        regAddr_t srcB;
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
    } dxReg_t;

    typedef struct packed {
        word_t    result;
        word_t    storeData;
        regAddr_t dest;
        regAddr_t storeSrc;
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
    } xmReg_t;

    typedef struct packed {
        word_t    result;
        word_t    loadData;
        regAddr_t dest;
        logic     regWrite;
        logic     memRead;
    } mwReg_t;

    typedef struct packed {
        logic     writeEn;
        regAddr_t dest;
        word_t    data;
    } wbBus_t;

    typedef enum logic [1:0] {
        fromReg,
        fromMem,
        fromWb
    } fwdSel_e;

    typedef struct packed {
        word_t addr;
        word_t writeData;
        logic  writeEn;
    } dmemReq_t;

    // Second source is rd for stores and branches and rt otherwise
    function automatic regAddr_t srcBIndex(instr_t instr);
        regAddr_t idx;
        case (instr.opcode)
            opSw, opBne, opBlt: idx = instr.rd;
            default:            idx = instr.rt;
        endcase
        return idx;
    endfunction

endpackage

//--- logic/decodeStage.sv
/*
 * Decode, register read and decode/execute register.
 * Source A is always rs; source B follows srcBIndex.
 * Unknown opcodes pass through with all control bits low.
 */
`timescale 1ns/1ps

module decodeStage import cpuPkg::*; (
    input  logic     clock,
    input  logic     rstN,
    input  logic     stall,
    input  logic     flush,
    input  fdReg_t   fd,
    output regAddr_t readAddrA,
    output regAddr_t readAddrB,
    input  word_t    readDataA,
    input  word_t    readDataB,
    output dxReg_t   dx
);

    word_t instrBits;
    word_t immExt;
    logic  regWrite;
    logic  memRead;
    logic  memWrite;

    assign instrBits = fd.instr;
    assign readAddrA = fd.instr.rs;
    assign readAddrB = srcBIndex(fd.instr);

    // Sign-extend the 17-bit immediate
    assign immExt = {{(dataWidth-immWidth){instrBits[immWidth-1]}},
                     instrBits[immWidth-1:0]};

    // Control bits from opcode
    always_comb begin
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        case (fd.instr.opcode)
            opRType, opAddi, opJal: regWrite = 1'b1;
            opLw: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
            end
            opSw:    memWrite = 1'b1;
            default: regWrite = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN || stall || flush) begin
            // Bubble on load-use or wrong path
            dx <= '0;
        end else begin
            dx.pcPlusOne <= fd.pcPlusOne;
            dx.instr     <= fd.instr;
            dx.imm       <= immExt;
            dx.dataA     <= readDataA;
            dx.dataB     <= readDataB;
            dx.srcA      <= readAddrA;
            dx.srcB      <= readAddrB;
            dx.regWrite  <= regWrite;
            dx.memRead   <= memRead;
            dx.memWrite  <= memWrite;
        end
    end

endmodule

//--- logic/executeStage.sv
/*
 * ALU, operand bypass, branch and jump resolution.
 * Shifts use shamt on operand A; sra is arithmetic.
 * Jump targets are zero-extended 27-bit word addresses.
 * Redirect is combinational and lands in fetch at the next edge.
 */
`timescale 1ns/1ps

module executeStage import cpuPkg::*; (
    input  logic    clock,
    input  logic    rstN,
    input  dxReg_t  dx,
    input  fwdSel_e fwdA,
    input  fwdSel_e fwdB,
    input  word_t   xmResult,
    input  wbBus_t  wb,
    output logic    redirect,
    output word_t   redirectPc,
    output xmReg_t  xm
);

    word_t  instrBits;
    word_t  opA;
    word_t  opB;
    word_t  aluB;
    word_t  aluResult;
    aluOp_e aluOp;
    logic   isBranch;
    logic   isJump;
    logic   isJal;
    logic   taken;

    function automatic word_t bypass(fwdSel_e sel, word_t regValue);
        word_t value;
        case (sel)
            fromMem: value = xmResult;
            fromWb:  value = wb.data;
            default: value = regValue;
        endcase
        return value;
    endfunction

    always_comb begin
        opA = bypass(fwdA, dx.dataA);
        opB = bypass(fwdB, dx.dataB);
    end

    assign instrBits = dx.instr;

    // Immediate forms add to rs
    always_comb begin
        case (dx.instr.opcode)
            opAddi, opLw, opSw: aluB = dx.imm;
            default:            aluB = opB;
        endcase
        aluOp = (dx.instr.opcode == opRType) ? dx.instr.aluOp : aluAdd;
    end

    always_comb begin
        case (aluOp)
            aluAdd:  aluResult = opA + aluB;
            aluSub:  aluResult = opA - aluB;
            aluAnd:  aluResult = opA & aluB;
            aluOr:   aluResult = opA | aluB;
            aluSll:  aluResult = opA << dx.instr.shamt;
            aluSra:  aluResult = $signed(opA) >>> dx.instr.shamt;
            default: aluResult = '0;
        endcase
    end

    // Branch compares rd (B) against rs (A)
    assign isBranch = (dx.instr.opcode == opBne && opB != opA)
                      || (dx.instr.opcode == opBlt && $signed(opB) < $signed(opA));
    assign isJal    = dx.instr.opcode == opJal;
    assign isJump   = dx.instr.opcode == opJ || isJal;
    assign taken    = isBranch || isJump;

    assign redirect   = taken;
    assign redirectPc = isJump
                        ? {{(dataWidth-targetWidth){1'b0}}, instrBits[targetWidth-1:0]}
                        : dx.pcPlusOne + dx.imm;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            xm <= '0;
        end else begin
            // jal links pc+1 into r31
            xm.result    <= isJal ? dx.pcPlusOne : aluResult;
            xm.dest      <= isJal ? regAddr_t'(linkReg) : dx.instr.rd;
            xm.storeData <= opB;
            xm.storeSrc  <= dx.srcB;
            xm.regWrite  <= dx.regWrite;
            xm.memRead   <= dx.memRead;
            xm.memWrite  <= dx.memWrite;
        end
    end

endmodule

//--- logic/fetchStage.sv
/*
 * PC and fetch/decode register.
 * Instruction memory must answer in the same cycle.
 * Redirect wins over stall; both never arrive together.
 */
`timescale 1ns/1ps

module fetchStage import cpuPkg::*; (
    input  logic   clock,
    input  logic   rstN,
    input  logic   stall,
    input  logic   flush,
    input  logic   redirect,
    input  word_t  redirectPc,
    output word_t  imemAddr,
    input  word_t  imemData,
    output fdReg_t fd
);

    word_t pc;
    word_t pcPlusOne;

    assign pcPlusOne = pc + 1'b1;
    assign imemAddr  = pc;

    // Next PC
    always_ff @(posedge clock) begin
        if (!rstN) begin
            pc <= '0;
        end else if (redirect) begin
            // Branch or jump resolved in execute
            pc <= redirectPc;
        end else if (!stall) begin
            pc <= pcPlusOne;
        end
    end

    // Fetch/decode register
    always_ff @(posedge clock) begin
        if (!rstN) begin
            fd <= '0;
        end else if (flush) begin
            // Wrong-path fetch becomes a bubble
            fd <= '0;
        end else if (!stall) begin
            fd.pcPlusOne <= pcPlusOne;
            fd.instr     <= imemData;
        end
    end

endmodule

//--- logic/hazardUnit.sv
/*
 * Load-use stall, flush and ALU forwarding select.
 * Memory stage beats write-back; r0 is never forwarded.
 * A load in memory is never forwarded since the stall covers it.
 */
`timescale 1ns/1ps

module hazardUnit import cpuPkg::*; (
    input  fdReg_t  fd,
    input  dxReg_t  dx,
    input  xmReg_t  xm,
    input  wbBus_t  wb,
    input  logic    redirect,
    output logic    stall,
    output logic    flush,
    output fwdSel_e fwdA,
    output fwdSel_e fwdB
);

    regAddr_t loadDest;

    // Load in execute feeding the instruction in decode
    assign loadDest = dx.instr.rd;
    assign stall = dx.memRead && loadDest != '0
                   && (loadDest == fd.instr.rs || loadDest == srcBIndex(fd.instr));

    assign flush = redirect;

    function automatic fwdSel_e pickFwd(regAddr_t src);
        fwdSel_e sel;
        if (xm.regWrite && xm.dest != '0 && xm.dest == src) begin
            sel = fromMem;
        end else if (wb.writeEn && wb.dest != '0 && wb.dest == src) begin
            sel = fromWb;
        end else begin
            sel = fromReg;
        end
        return sel;
    endfunction

    always_comb begin
        fwdA = pickFwd(dx.srcA);
        fwdB = pickFwd(dx.srcB);
    end

endmodule

//--- logic/memWriteback.sv
/*
 * Data-memory request, memory/write-back register, write-back mux.
 * Data memory must answer loads in the same cycle.
 * The write-back bus is combinational from the memory/write-back register.
 */
`timescale 1ns/1ps

module memWriteback import cpuPkg::*; (
    input  logic     clock,
    input  logic     rstN,
    input  xmReg_t   xm,
    output dmemReq_t dmemReq,
    input  word_t    dmemReadData,
    output wbBus_t   wb
);

    mwReg_t mw;
    logic   storeBypass;

    // Store data from the instruction now writing back
    assign storeBypass = wb.writeEn && wb.dest != '0 && wb.dest == xm.storeSrc;

    always_comb begin
        dmemReq.addr      = xm.result;
        dmemReq.writeData = storeBypass ? wb.data : xm.storeData;
        dmemReq.writeEn   = xm.memWrite;
    end

    // Payload of the memory/write-back register
    always_ff @(posedge clock) begin
        mw.result   <= xm.result;
        mw.loadData <= dmemReadData;
        mw.dest     <= xm.dest;
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            mw.regWrite <= 1'b0;
            mw.memRead  <= 1'b0;
        end else begin
            mw.regWrite <= xm.regWrite;
            mw.memRead  <= xm.memRead;
        end
    end

    // Load data or ALU result
    always_comb begin
        wb.writeEn = mw.regWrite;
        wb.dest    = mw.dest;
        wb.data    = mw.memRead ? mw.loadData : mw.result;
    end

endmodule

//--- logic/pipelineCpu.sv
/*
 * Five-stage core top: fetch, decode, execute, memory, write-back.
 * Both memories sit outside and answer combinationally, no handshake.
 * Synchronous active-low reset clears PC, stage controls and registers.
 */
`timescale 1ns/1ps

module pipelineCpu import cpuPkg::*; (
    input  logic     clock,
    input  logic     rstN,
    output word_t    imemAddr,
    input  word_t    imemData,
    output dmemReq_t dmemReq,
    input  word_t    dmemReadData
);

    fdReg_t   fd;
    dxReg_t   dx;
    xmReg_t   xm;
    wbBus_t   wb;
    regAddr_t readAddrA;
    regAddr_t readAddrB;
    word_t    readDataA;
    word_t    readDataB;
    logic     stall;
    logic     flush;
    logic     redirect;
    word_t    redirectPc;
    fwdSel_e  fwdA;
    fwdSel_e  fwdB;

    fetchStage fetch (
        .clock, .rstN, .stall, .flush, .redirect, .redirectPc,
        .imemAddr, .imemData, .fd
    );

    // Register file beside the decode datapath
    regFile regs (
        .clock, .rstN, .readAddrA, .readAddrB, .readDataA, .readDataB, .wb
    );

    decodeStage decode (
        .clock, .rstN, .stall, .flush, .fd,
        .readAddrA, .readAddrB, .readDataA, .readDataB, .dx
    );

    hazardUnit hazard (
        .fd, .dx, .xm, .wb, .redirect, .stall, .flush, .fwdA, .fwdB
    );

    executeStage execute (
        .clock, .rstN, .dx, .fwdA, .fwdB, .xmResult(xm.result), .wb,
        .redirect, .redirectPc, .xm
    );

    memWriteback memWb (
        .clock, .rstN, .xm, .dmemReq, .dmemReadData, .wb
    );

endmodule

//--- logic/regFile.sv
/*
 * Two read ports, one write port from write-back.
 * Reads are combinational and see a same-cycle write.
 * r0 always reads zero and ignores writes.
 */
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
    input  logic     clock,
    input  logic     rstN,
    input  regAddr_t readAddrA,
    input  regAddr_t readAddrB,
    output word_t    readDataA,
    output word_t    readDataB,
    input  wbBus_t   wb
);

    // r0 not stored
    word_t regs [1:31];

    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.writeEn && wb.dest != '0) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // Write-through read
    function automatic word_t readPort(regAddr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wb.writeEn && wb.dest == addr) begin
            value = wb.data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        readDataA = readPort(readAddrA);
        readDataB = readPort(readAddrB);
    end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module cpuTb -f verilog.f -o cpuTbSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/cpuTbSim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi
exit 0

//--- verification/cpuPrograms.svh
/*
 * Test programs with their expected stores, one entry per test.
 * Code words are built by the encoder functions of the testbench.
 * Unused code words stay zero, which is add r0, r0, r0.
 * Data addresses are word indices below 64.
 */
`ifndef CPU_PROGRAMS_SVH
`define CPU_PROGRAMS_SVH

localparam int numTests = 5;

task automatic buildTable();
    for (int t = 0; t < numTests; t++) begin
        for (int i = 0; i < 16; i++) progCode[t][i] = 32'h0;
        for (int i = 0; i < 8; i++) expStores[t][i] = '0;
    end
    // Write to r0 is dropped, so r0 stores as 0
    progCode[0][0] = iOp(opAddi, 0, 0, 5);
    progCode[0][1] = iOp(opSw, 0, 0, 0);
    progCode[0][2] = jOp(opJ, 2);
    expCount[0] = 1;
    expStores[0][0] = '{addr: 32'd0, data: 32'd0};
    // Back-to-back ALU chain
    progCode[1][0]  = iOp(opAddi, 1, 0, 7);
    progCode[1][1]  = iOp(opAddi, 2, 1, -3);
    progCode[1][2]  = rOp(aluAdd, 3, 1, 2, 0);
    progCode[1][3]  = rOp(aluSub, 4, 3, 1, 0);
    progCode[1][4]  = rOp(aluOr, 5, 3, 2, 0);
    progCode[1][5]  = rOp(aluSll, 6, 5, 0, 4);
    progCode[1][6]  = iOp(opAddi, 7, 0, -16);
    progCode[1][7]  = rOp(aluSra, 8, 7, 0, 2);
    progCode[1][8]  = rOp(aluAnd, 9, 8, 5, 0);
    progCode[1][9]  = iOp(opSw, 3, 0, 1);
    progCode[1][10] = iOp(opSw, 4, 0, 2);
    progCode[1][11] = iOp(opSw, 5, 0, 3);
    progCode[1][12] = iOp(opSw, 6, 0, 4);
    progCode[1][13] = iOp(opSw, 8, 0, 5);
    progCode[1][14] = iOp(opSw, 9, 0, 6);
    progCode[1][15] = jOp(opJ, 15);
    expCount[1] = 6;
    expStores[1][0] = '{addr: 32'd1, data: 32'd11};
    expStores[1][1] = '{addr: 32'd2, data: 32'd4};
    expStores[1][2] = '{addr: 32'd3, data: 32'd15};
    expStores[1][3] = '{addr: 32'd4, data: 32'd240};
    expStores[1][4] = '{addr: 32'd5, data: 32'hFFFF_FFFC};
    expStores[1][5] = '{addr: 32'd6, data: 32'd12};
    // Store, load back, use at once
    progCode[2][0] = iOp(opAddi, 1, 0, 42);
    progCode[2][1] = iOp(opSw, 1, 0, 8);
    progCode[2][2] = iOp(opLw, 2, 0, 8);
    progCode[2][3] = rOp(aluAdd, 3, 2, 2, 0);
    progCode[2][4] = iOp(opSw, 3, 0, 9);
    progCode[2][5] = iOp(opLw, 4, 0, 8);
    progCode[2][6] = iOp(opSw, 4, 0, 10);
    progCode[2][7] = jOp(opJ, 7);
    expCount[2] = 3;
    expStores[2][0] = '{addr: 32'd8, data: 32'd42};
    expStores[2][1] = '{addr: 32'd9, data: 32'd84};
    expStores[2][2] = '{addr: 32'd10, data: 32'd42};
    // Taken and not-taken bne and blt
    progCode[3][0]  = iOp(opAddi, 1, 0, 1);
    progCode[3][1]  = iOp(opAddi, 2, 0, 2);
    progCode[3][2]  = iOp(opBne, 1, 2, 2);
    progCode[3][3]  = iOp(opSw, 1, 0, 16);
    progCode[3][4]  = iOp(opSw, 2, 0, 17);
    progCode[3][5]  = iOp(opBne, 1, 1, 2);
    progCode[3][6]  = iOp(opSw, 1, 0, 18);
    progCode[3][7]  = iOp(opBlt, 1, 2, 2);
    progCode[3][8]  = iOp(opSw, 1, 0, 19);
    progCode[3][9]  = iOp(opSw, 2, 0, 20);
    progCode[3][10] = iOp(opBlt, 2, 1, 2);
    progCode[3][11] = iOp(opSw, 2, 0, 21);
    progCode[3][12] = jOp(opJ, 12);
    expCount[3] = 2;
    expStores[3][0] = '{addr: 32'd18, data: 32'd1};
    expStores[3][1] = '{addr: 32'd21, data: 32'd2};
    // j over shadow stores, jal links 4 + 1
    progCode[4][0] = iOp(opAddi, 1, 0, 9);
    progCode[4][1] = jOp(opJ, 4);
    progCode[4][2] = iOp(opSw, 1, 0, 24);
    progCode[4][3] = iOp(opSw, 1, 0, 25);
    progCode[4][4] = jOp(opJal, 7);
    progCode[4][5] = iOp(opSw, 1, 0, 26);
    progCode[4][6] = iOp(opSw, 1, 0, 27);
    progCode[4][7] = iOp(opSw, 31, 0, 28);
    progCode[4][8] = iOp(opSw, 1, 0, 29);
    progCode[4][9] = jOp(opJ, 9);
    expCount[4] = 2;
    expStores[4][0] = '{addr: 32'd28, data: 32'd5};
    expStores[4][1] = '{addr: 32'd29, data: 32'd9};
endtask

`endif

//--- verification/cpuTb.sv
/*
 * Testbench for the five-stage core.
 * Memories answer combinationally; stores land on the rising edge.
 * Each program is reset and run for 60 cycles, stores checked in order.
 * First mismatch ends the run.
 */
`timescale 1ns/1ps

module cpuTb import cpuPkg::*; ();

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } storePair_t;

    // Encodings from the instruction format
    localparam int opJ = 1, opBne = 2, opJal = 3, opAddi = 5;
    localparam int opBlt = 6, opSw = 7, opLw = 8;
    localparam int aluAdd = 0, aluSub = 1, aluAnd = 2, aluOr = 3, aluSll = 4, aluSra = 5;
    localparam int runCycles = 60;

    logic        clock = 1'b0;
    logic        rstN = 1'b0;
    logic [31:0] imemAddr;
    logic [31:0] imemData;
    dmemReq_t    dmemReq;
    logic [31:0] dmemReadData;

    logic [31:0] imem [0:31];
    logic [31:0] dmem [0:63];
    logic [31:0] progCode [5][16];
    int          expCount [5];
    storePair_t  expStores [5][8];
    logic        running = 1'b0;
    int          testIdx = 0;
    int          storeIdx = 0;

    function automatic logic [31:0] rOp(int alu, int rd, int rs, int rt, int shamt);
        return {5'd0, rd[4:0], rs[4:0], rt[4:0], shamt[4:0], alu[4:0], 2'b00};
    endfunction

    function automatic logic [31:0] iOp(int op, int rd, int rs, int imm);
        return {op[4:0], rd[4:0], rs[4:0], imm[16:0]};
    endfunction

    function automatic logic [31:0] jOp(int op, int target);
        return {op[4:0], target[26:0]};
    endfunction

    `include "cpuPrograms.svh"

    task automatic stopOnError(string line);
        $display("%s", line);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    always #20 clock = ~clock;

    assign imemData     = imem[imemAddr[4:0]];
    assign dmemReadData = dmem[dmemReq.addr[5:0]];

    pipelineCpu UUT (
        .clock, .rstN, .imemAddr, .imemData, .dmemReq, .dmemReadData
    );

    // Store monitor and data memory write
    always @(posedge clock) begin
        if (running && dmemReq.writeEn === 1'b1) begin
            assert (storeIdx < expCount[testIdx])
            else stopOnError($sformatf("Test %0d made an unexpected extra store at %0t",
                                       testIdx, $time));
            assert (dmemReq.addr === expStores[testIdx][storeIdx].addr)
            else stopOnError($sformatf("FAILED %0t dmemReq.addr expected %h actual %h",
                                       $time, expStores[testIdx][storeIdx].addr,
                                       dmemReq.addr));
            assert (dmemReq.writeData === expStores[testIdx][storeIdx].data)
            else stopOnError($sformatf("FAILED %0t dmemReq.writeData expected %h actual %h",
                                       $time, expStores[testIdx][storeIdx].data,
                                       dmemReq.writeData));
            storeIdx = storeIdx + 1;
            dmem[dmemReq.addr[5:0]] <= dmemReq.writeData;
        end
    end

    // Watchdog allows 70 cycles per test
    initial begin
        #(numTests * 70 * 40);
        stopOnError("Watchdog timeout, the test loop did not finish in time");
    end

    initial begin
        buildTable();
        for (int t = 0; t < numTests; t++) begin
            // Next program loaded between runs
            for (int i = 0; i < 32; i++) imem[i] = (i < 16) ? progCode[t][i] : 32'h0;
            for (int i = 0; i < 64; i++) dmem[i] = 32'h0;
            testIdx  = t;
            storeIdx = 0;
            @(posedge clock);
            rstN <= 1'b0;
            repeat (4) @(posedge clock);
            rstN    <= 1'b1;
            running <= 1'b1;
            #1;
            assert (imemAddr === 32'h0)
            else stopOnError($sformatf("FAILED %0t imemAddr expected %h actual %h",
                                       $time, 32'h0, imemAddr));
            repeat (runCycles) @(posedge clock);
            running <= 1'b0;
            #1;
            assert (storeIdx == expCount[t])
            else stopOnError($sformatf("Test %0d made %0d stores but %0d were expected",
                                       t, storeIdx, expCount[t]));
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verification
logic/cpuPkg.sv
logic/fetchStage.sv
logic/regFile.sv
logic/decodeStage.sv
logic/hazardUnit.sv
logic/executeStage.sv
logic/memWriteback.sv
logic/pipelineCpu.sv
verification/cpuTb.sv
